// ==== include/lvds_rx_params.svh ====
`ifndef LVDS_RX_PARAMS_SVH
`define LVDS_RX_PARAMS_SVH

// ------------------------------------------------------------------------
// Lane geometry
// ------------------------------------------------------------------------

// Number of serial lanes
`define LVDS_RX_LANES 4

// Bits per deserialized word, MSB arrives first
`define LVDS_RX_WORD_W 8

// Delay tap width, 0 to 31 bit periods
`define LVDS_RX_TAP_W 5

// ------------------------------------------------------------------------
// Register map, word addresses
// ------------------------------------------------------------------------

// Lane select, tap load and command strobes
`define LVDS_RX_ADDR_CTRL 2'd0

// Read-only view of the selected lane
`define LVDS_RX_ADDR_STATUS 2'd1

`endif

// ==== rtl/lvds_rx_reg_pkg.sv ====
`default_nettype none

`include "lvds_rx_params.svh"

package lvds_rx_reg_pkg;

    // --------------------------------------------------------------------
    // Register addresses
    // --------------------------------------------------------------------

    // Address 2 and 3 are unmapped and read zero
    typedef enum logic [1:0] {
        REG_CTRL   = `LVDS_RX_ADDR_CTRL,
        REG_STATUS = `LVDS_RX_ADDR_STATUS
    } reg_addr_e;

    // --------------------------------------------------------------------
    // Wishbone cycle state
    // --------------------------------------------------------------------

    // Idle waits for cyc and stb, ack lasts exactly one cycle
    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

endpackage

`default_nettype wire

// ==== rtl/lvds_rx_lane_pkg.sv ====
`default_nettype none

`include "lvds_rx_params.svh"

package lvds_rx_lane_pkg;

    // One deserialized word, bit 7 was received first
    typedef logic [`LVDS_RX_WORD_W-1:0] lane_word_t;

    // Delay tap in bit periods
    typedef logic [`LVDS_RX_TAP_W-1:0] tap_t;

endpackage

`default_nettype wire

// ==== rtl/lane_ctrl_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

interface lane_ctrl_if
    import lvds_rx_lane_pkg::*;
#(
    parameter int LANES = `LVDS_RX_LANES
) ();

    // Commands from the register block, strobes are one bit per lane
    tap_t             tap_val;
    logic [LANES-1:0] tap_ld;
    logic [LANES-1:0] slip;
    logic [LANES-1:0] lane_rst;

    // Monitor values, each lane drives its own element
    tap_t             tap_mon  [LANES];
    lane_word_t       word_mon [LANES];

    modport regs (
        output tap_val, tap_ld, slip, lane_rst,
        input  tap_mon, word_mon
    );

    modport lane (
        input  tap_val, tap_ld, slip, lane_rst,
        output tap_mon, word_mon
    );

endinterface

`default_nettype wire

// ==== rtl/lvds_rx_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module lvds_rx_regs
    import lvds_rx_reg_pkg::*;
    import lvds_rx_lane_pkg::*;
#(
    parameter int LANES = `LVDS_RX_LANES
) (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         wb_cyc,
    input  wire         wb_stb,
    input  wire         wb_we,
    input  wire  [1:0]  wb_adr,
    input  wire  [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    lane_ctrl_if.regs   ctrl
);

    // REG_CTRL field positions
    localparam int TAP_LSB  = 8;
    localparam int RST_BIT  = 16;
    localparam int SLIP_BIT = 17;

    wb_state_e        state;
    reg_addr_e        adr_q;
    logic             we_q;
    logic             slip_req_q;
    logic             rst_req_q;
    tap_t             tap_q;
    logic [7:0]       sel;
    logic             wr_ctrl;
    logic [LANES-1:0] lane_hot;
    tap_t             mon_tap;
    lane_word_t       mon_word;

    // ------------------------------------------------------------------------
    // Wishbone cycle handling
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WB_IDLE;
            sel   <= '0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (wb_cyc && wb_stb) begin
                        state <= WB_ACK;
                        // Lane select is live in the ack cycle
                        if (wb_we && reg_addr_e'(wb_adr) == REG_CTRL) begin
                            sel <= wb_dat_w[7:0];
                        end
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Access details, only looked at while acking
    always_ff @(posedge clk) begin
        if (state == WB_IDLE && wb_cyc && wb_stb) begin
            adr_q      <= reg_addr_e'(wb_adr);
            we_q       <= wb_we;
            tap_q      <= wb_dat_w[TAP_LSB +: $bits(tap_t)];
            slip_req_q <= wb_dat_w[SLIP_BIT];
            rst_req_q  <= wb_dat_w[RST_BIT];
        end
    end

    assign wb_ack = (state == WB_ACK);

    // ------------------------------------------------------------------------
    // Lane strobes
    // ------------------------------------------------------------------------

    assign wr_ctrl = wb_ack && we_q && (adr_q == REG_CTRL);

    // Selects of LANES or more shift the bit out and strobe nothing
    assign lane_hot = LANES'(1) << sel;

    assign ctrl.tap_val  = tap_q;
    assign ctrl.tap_ld   = wr_ctrl ? lane_hot : '0;
    assign ctrl.slip     = (wr_ctrl && slip_req_q) ? lane_hot : '0;
    assign ctrl.lane_rst = (wr_ctrl && rst_req_q) ? lane_hot : '0;

    // ------------------------------------------------------------------------
    // Readback
    // ------------------------------------------------------------------------

    always_comb begin
        mon_tap  = '0;
        mon_word = '0;
        for (int i = 0; i < LANES; i++) begin
            if (sel == 8'(i)) begin
                mon_tap  = ctrl.tap_mon[i];
                mon_word = ctrl.word_mon[i];
            end
        end
    end

    always_comb begin
        wb_dat_r = '0;
        if (wb_ack && !we_q) begin
            case (adr_q)
                REG_CTRL:   wb_dat_r = {24'h0, sel};
                REG_STATUS: wb_dat_r = {8'h0, mon_word, 3'h0, mon_tap, sel};
                default:    wb_dat_r = '0;
            endcase
        end
    end

    // An ack is always the answer to a request one cycle earlier, and never repeats
    ack_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb) ##1 !wb_ack
    );

    // At most one lane sees any command
    strobes_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(ctrl.tap_ld) && $onehot0(ctrl.slip) && $onehot0(ctrl.lane_rst)
    );

endmodule

`default_nettype wire

// ==== rtl/lvds_rx_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module lvds_rx_lane
    import lvds_rx_lane_pkg::*;
#(
    parameter int LANE_IDX = 0
) (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        in_d,
    output lane_word_t word,
    output logic       word_stb,
    lane_ctrl_if.lane  ctrl
);

    localparam int WORD_W  = `LVDS_RX_WORD_W;
    localparam int DLY_LEN = 1 << `LVDS_RX_TAP_W;
    localparam int CNT_W   = $clog2(WORD_W);

    logic [DLY_LEN-1:0] dly_q;
    tap_t               tap_q;
    logic               dly_bit;
    lane_word_t         shift_q;
    logic [CNT_W-1:0]   cnt;
    logic               frame_end;

    // ------------------------------------------------------------------------
    // Delay line
    // ------------------------------------------------------------------------

    // Stage 0 is the sampled input, each further stage adds one bit period
    always_ff @(posedge clk) begin
        dly_q <= {dly_q[DLY_LEN-2:0], in_d};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap_q <= '0;
        end else if (ctrl.tap_ld[LANE_IDX]) begin
            tap_q <= ctrl.tap_val;
        end
    end

    assign dly_bit = dly_q[tap_q];

    assign ctrl.tap_mon[LANE_IDX] = tap_q;

    // ------------------------------------------------------------------------
    // Deserializer
    // ------------------------------------------------------------------------

    // Assembly register, MSB first
    always_ff @(posedge clk) begin
        shift_q <= {shift_q[WORD_W-2:0], dly_bit};
    end

    // Bitslip stretches the current frame by one bit
    assign frame_end = (cnt == CNT_W'(WORD_W - 1)) && !ctrl.slip[LANE_IDX];

    always_ff @(posedge clk) begin
        if (!rst_n || ctrl.lane_rst[LANE_IDX]) begin
            cnt      <= '0;
            word     <= '0;
            word_stb <= 1'b0;
        end else begin
            word_stb <= frame_end;
            if (frame_end) begin
                cnt  <= '0;
                word <= {shift_q[WORD_W-2:0], dly_bit};
            end else if (!ctrl.slip[LANE_IDX]) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign ctrl.word_mon[LANE_IDX] = word;

    // Software never requests slip and lane reset in the same write
    no_slip_during_rst: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(ctrl.slip[LANE_IDX] && ctrl.lane_rst[LANE_IDX])
    );

endmodule

`default_nettype wire

// ==== rtl/lvds_rx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module lvds_rx_top
    import lvds_rx_lane_pkg::*;
#(
    parameter int LANES = `LVDS_RX_LANES
) (
    input  wire                            clk,
    input  wire                            rst_n,

    // Wishbone classic slave
    input  wire                            wb_cyc,
    input  wire                            wb_stb,
    input  wire                            wb_we,
    input  wire  [1:0]                     wb_adr,
    input  wire  [31:0]                    wb_dat_w,
    output logic [31:0]                    wb_dat_r,
    output logic                           wb_ack,

    // Serial lanes and parallel words
    input  wire  [LANES-1:0]               in_d,
    output logic [`LVDS_RX_WORD_W*LANES-1:0] dout,
    output logic [LANES-1:0]               word_stb,
    output logic [`LVDS_RX_WORD_W*LANES-1:0] adc_out
);

    localparam int WORD_W = `LVDS_RX_WORD_W;

    lane_word_t lane_word [LANES];

    lane_ctrl_if #(.LANES(LANES)) ctrl_if ();

    lvds_rx_regs #(
        .LANES    (LANES)
    ) i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ctrl     (ctrl_if.regs)
    );

    // ------------------------------------------------------------------------
    // Lane array and output mapping
    // ------------------------------------------------------------------------

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        lvds_rx_lane #(
            .LANE_IDX (i)
        ) i_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_d     (in_d[i]),
            .word     (lane_word[i]),
            .word_stb (word_stb[i]),
            .ctrl     (ctrl_if.lane)
        );

        assign dout[WORD_W*i +: WORD_W] = lane_word[i];

        // Bit j of every lane grouped together, as the ADC data sheet orders them
        for (genvar j = 0; j < WORD_W; j++) begin : g_bit
            assign adc_out[LANES*j + i] = lane_word[i][j];
        end
    end

endmodule

`default_nettype wire

// ==== bench/lvds_rx_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module lvds_rx_checker
    import lvds_rx_lane_pkg::*;
#(
    parameter int LANES = `LVDS_RX_LANES
) (
    input wire                               clk,
    input wire                               rst_n,
    input wire                               wb_cyc,
    input wire                               wb_stb,
    input wire                               wb_we,
    input wire                               wb_ack,
    input wire [31:0]                        wb_dat_r,
    input wire [`LVDS_RX_WORD_W*LANES-1:0]   dout,
    input wire [`LVDS_RX_WORD_W*LANES-1:0]   adc_out,
    input wire [LANES-1:0]                   word_stb
);

    localparam int W = `LVDS_RX_WORD_W;

    int          value_errors = 0;
    int          other_errors = 0;
    int          ack_count = 0;
    int          stb_count [LANES];
    int          stb_gap [LANES];
    bit          gap_valid [LANES];
    bit          wr_seen [LANES];
    lane_word_t  last_word [LANES];
    lane_word_t  snap_word [LANES];
    logic        ack_q = 1'b0;
    logic        req_q = 1'b0;
    int          read_mode = 0;
    string       read_name;
    logic [31:0] read_exp;
    logic [31:0] read_mask;

    initial begin
        for (int i = 0; i < LANES; i++) begin
            stb_count[i] = 0;
            stb_gap[i]   = 0;
            gap_valid[i] = 1'b0;
            wr_seen[i]   = 1'b0;
            last_word[i] = '0;
            snap_word[i] = '0;
        end
    end

    // ------------------------------------------------------------------------
    // Reporting and helpers
    // ------------------------------------------------------------------------

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        value_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at %0t: %s", $time, msg);
        other_errors++;
    endtask

    function automatic lane_word_t rotl(input lane_word_t w, input int n);
        logic [2*W-1:0] t;
        t = {w, w} << (n % W);
        return t[2*W-1:W];
    endfunction

    function automatic lane_word_t dout_word(input int lane);
        return dout[W*lane +: W];
    endfunction

    // ------------------------------------------------------------------------
    // Requests from the testbench
    // ------------------------------------------------------------------------

    // Mode 1 compares the masked read data, mode 2 the lane select and word of REG_STATUS
    task automatic expect_read(input string name, input int mode,
                               input logic [31:0] exp, input logic [31:0] mask);
        read_name = name;
        read_mode = mode;
        read_exp  = exp;
        read_mask = mask;
    endtask

    task automatic take_snapshot();
        for (int i = 0; i < LANES; i++) begin
            snap_word[i] = last_word[i];
        end
    endtask

    task automatic check_rotation(input string name, input int lane, input int n);
        if (last_word[lane] !== rotl(snap_word[lane], n)) begin
            value_error(name, rotl(snap_word[lane], n), last_word[lane]);
        end
    endtask

    task automatic check_word(input string name, input int lane, input lane_word_t exp);
        if (dout_word(lane) !== exp) begin
            value_error(name, exp, dout_word(lane));
        end
    endtask

    // Any of the eight rotations of the training pattern is a valid frame
    task automatic check_pattern(input string name, input int lane, input lane_word_t pat);
        bit found;
        found = 1'b0;
        for (int r = 0; r < W; r++) begin
            if (last_word[lane] === rotl(pat, r)) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            value_error(name, pat, last_word[lane]);
        end
    endtask

    task automatic check_acks(input int accesses);
        if (ack_count != accesses) begin
            value_error("ack_count", accesses, ack_count);
        end
    endtask

    // ------------------------------------------------------------------------
    // Port monitor, sampled mid-cycle
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        int         sel;
        lane_word_t exp_w;
        lane_word_t mapped;
        if (rst_n) begin
            if (wb_ack && !req_q) begin
                report_failure("wb_ack rose without a preceding cyc and stb");
            end
            if (wb_ack && ack_q) begin
                report_failure("wb_ack stayed high for more than one cycle");
            end
            if (wb_ack && !ack_q) begin
                ack_count++;
            end
            if (wb_ack && read_mode == 1) begin
                if ((wb_dat_r & read_mask) !== read_exp) begin
                    value_error(read_name, read_exp, wb_dat_r & read_mask);
                end
            end else if (wb_ack && read_mode == 2) begin
                sel   = int'(read_exp[7:0]);
                exp_w = (sel < LANES) ? dout_word(sel) : '0;
                if (wb_dat_r[7:0] !== read_exp[7:0]) begin
                    value_error(read_name, read_exp[7:0], wb_dat_r[7:0]);
                end
                if (wb_dat_r[23:16] !== exp_w) begin
                    value_error(read_name, exp_w, wb_dat_r[23:16]);
                end
            end
            if (wb_ack) begin
                read_mode = 0;
            end
            for (int i = 0; i < LANES; i++) begin
                stb_gap[i]++;
                if (word_stb[i]) begin
                    // A frame lasts eight cycles unless a register write slipped or reset it
                    if (gap_valid[i] && !wr_seen[i] && stb_gap[i] != W) begin
                        value_error($sformatf("word_stb_gap_lane%0d", i), W, stb_gap[i]);
                    end
                    stb_gap[i]   = 0;
                    gap_valid[i] = 1'b1;
                    wr_seen[i]   = 1'b0;
                    last_word[i] = dout_word(i);
                    stb_count[i]++;
                    // Bit j of lane i sits at LANES*j + i
                    for (int j = 0; j < W; j++) begin
                        mapped[j] = adc_out[LANES*j + i];
                    end
                    if (mapped !== dout_word(i)) begin
                        value_error($sformatf("adc_out_lane%0d", i), dout_word(i), mapped);
                    end
                end
            end
            if (wb_ack && wb_we) begin
                for (int i = 0; i < LANES; i++) begin
                    wr_seen[i] = 1'b1;
                end
            end
        end
        ack_q = wb_ack;
        req_q = wb_cyc && wb_stb;
    end

endmodule

`default_nettype wire

// ==== bench/tb_lvds_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "lvds_rx_params.svh"

module tb_lvds_rx;

    localparam int LANES = `LVDS_RX_LANES;
    localparam int W     = `LVDS_RX_WORD_W;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [1:0]         wb_adr;
    logic [31:0]        wb_dat_w;
    logic [31:0]        wb_dat_r;
    logic               wb_ack;
    logic [LANES-1:0]   in_d;
    logic [W*LANES-1:0] dout;
    logic [LANES-1:0]   word_stb;
    logic [W*LANES-1:0] adc_out;

    logic [W-1:0]       pattern [LANES];
    logic [2:0]         bit_idx = '0;
    logic [7:0]         lane_sel = '0;
    string              t_name [$];
    string              t_kind [$];
    logic [31:0]        t_a [$];
    logic [31:0]        t_b [$];
    logic [31:0]        t_exp [$];
    int                 accesses = 0;
    bit                 loaded = 1'b0;

    lvds_rx_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .in_d     (in_d),
        .dout     (dout),
        .word_stb (word_stb),
        .adc_out  (adc_out)
    );

    lvds_rx_checker i_chk (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .dout     (dout),
        .adc_out  (adc_out),
        .word_stb (word_stb)
    );

    always #5 clk = ~clk;

    // Serial lanes, each repeats its training pattern MSB first
    always @(posedge clk) begin
        #1;
        for (int i = 0; i < LANES; i++) begin
            in_d[i] = pattern[i][W-1-bit_idx];
        end
        bit_idx = bit_idx + 1'b1;
    end

    // ------------------------------------------------------------------------
    // Test file and bus tasks
    // ------------------------------------------------------------------------

    task automatic load_tests();
        int          fd;
        int          code;
        string       name;
        string       kind;
        string       rest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e;
        fd = $fopen("bench/lvds_rx_tests.txt", "r");
        if (fd == 0) begin
            i_chk.report_failure("cannot open bench/lvds_rx_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) begin
                break;
            end
            if (name.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%s %h %h %h", kind, a, b, e);
                t_name.push_back(name);
                t_kind.push_back(kind);
                t_a.push_back(a);
                t_b.push_back(b);
                t_exp.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    task automatic bus_access(input logic we, input logic [1:0] adr,
                              input logic [31:0] dat, input string name);
        int n;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            i_chk.report_failure({"no wb_ack within 20 cycles in ", name});
        end
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        accesses++;
    endtask

    task automatic wait_word_stb(input int lane, input int count, input string name);
        int start;
        int n;
        for (int k = 0; k < count; k++) begin
            start = i_chk.stb_count[lane];
            n = 0;
            while (i_chk.stb_count[lane] == start && n < 20) begin
                @(posedge clk);
                n++;
            end
            if (i_chk.stb_count[lane] == start) begin
                i_chk.report_failure($sformatf("no word_stb on lane %0d within 20 cycles in %s",
                                               lane, name));
            end
        end
        #1;
    endtask

    task automatic run_test(input int i);
        case (t_kind[i])
            "pat":   pattern[t_a[i]] = t_b[i][W-1:0];
            "wr": begin
                // Every REG_CTRL write moves the lane select
                if (t_a[i][1:0] == `LVDS_RX_ADDR_CTRL) begin
                    lane_sel = t_b[i][7:0];
                end
                bus_access(1'b1, t_a[i][1:0], t_b[i], t_name[i]);
            end
            "rd": begin
                i_chk.expect_read(t_name[i], 1, t_exp[i], t_b[i]);
                bus_access(1'b0, t_a[i][1:0], '0, t_name[i]);
            end
            "stw": begin
                i_chk.expect_read(t_name[i], 2, {24'h0, lane_sel}, '0);
                bus_access(1'b0, t_a[i][1:0], '0, t_name[i]);
            end
            "wait":  wait_word_stb(t_a[i], t_b[i], t_name[i]);
            "snap":  i_chk.take_snapshot();
            "rotl":  i_chk.check_rotation(t_name[i], t_a[i], t_b[i]);
            "word":  i_chk.check_word(t_name[i], t_a[i], t_exp[i][W-1:0]);
            "isrot": i_chk.check_pattern(t_name[i], t_a[i], pattern[t_a[i]]);
            default: i_chk.report_failure({"unknown test kind ", t_kind[i]});
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------

    initial begin
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        in_d     = '0;
        for (int i = 0; i < LANES; i++) begin
            pattern[i] = '0;
        end
        load_tests();
        if (t_name.size() == 0) begin
            i_chk.report_failure("the test file holds no tests");
        end
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
        end
        repeat (2) @(posedge clk);
        i_chk.check_acks(accesses);
        $display("Done: %0d value errors, %0d other errors",
                 i_chk.value_errors, i_chk.other_errors);
        if (i_chk.value_errors == 0 && i_chk.other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (t_name.size() * 200 + 100) @(posedge clk);
        $display("Failure: watchdog expired, the tests did not finish in time");
        $display("Done: %0d value errors, %0d other errors",
                 i_chk.value_errors, i_chk.other_errors + 1);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/lvds_rx_tests.txt ====
# name kind arg_a arg_b expected, numbers in hex
# pat lane pattern, wr/rd/stw addr data-or-mask, wait lane count, rotl lane bits, word lane
pat_l0 pat 0 1d 0
pat_l1 pat 1 2c 0
pat_l2 pat 2 47 0
pat_l3 pat 3 0b 0
settle wait 0 4 0
init_rot_l0 isrot 0 0 0
init_rot_l3 isrot 3 0 0
sel_l2 wr 0 00000002 0
rd_ctrl rd 0 ffffffff 00000002
sel_oor wr 0 00000307 0
rd_oor rd 1 ffffffff 00000007
tap_l1 wr 0 00000301 0
tap_l3 wr 0 00000903 0
rd_tap_l3 rd 1 00001fff 00000903
sel_l1 wr 0 00000301 0
rd_tap_l1 rd 1 00001fff 00000301
settle_taps wait 0 3 0
snap_slip snap 0 0 0
slip_l2 wr 0 00020002 0
slip_wait wait 2 2 0
slip_rot_l2 rotl 2 1 0
slip_keep_l0 rotl 0 0 0
slip_keep_l1 rotl 1 0 0
slip_keep_l3 rotl 3 0 0
snap_tap0 snap 0 0 0
tap_l0 wr 0 00000500 0
tap_wait_l0 wait 0 2 0
tap_rot_l0 rotl 0 3 0
snap_tap3 snap 0 0 0
tap_l3_up wr 0 00001403 0
tap_wait_l3 wait 3 2 0
tap_rot_l3 rotl 3 5 0
stw_l3 stw 1 0 0
rst_l1 wr 0 00010301 0
rst_zero_l1 word 1 0 0
rst_wait_l1 wait 1 1 0
rst_rot_l1 isrot 1 0 0
stw_l1 stw 1 0 0

// ==== src.f ====
+incdir+include
rtl/lvds_rx_reg_pkg.sv
rtl/lvds_rx_lane_pkg.sv
rtl/lane_ctrl_if.sv
rtl/lvds_rx_regs.sv
rtl/lvds_rx_lane.sv
rtl/lvds_rx_top.sv
bench/lvds_rx_checker.sv
bench/tb_lvds_rx.sv

// ==== Bender.yml ====
package:
  name: lvds_rx

sources:
  - include_dirs:
      - include
    files:
      - rtl/lvds_rx_reg_pkg.sv
      - rtl/lvds_rx_lane_pkg.sv
      - rtl/lane_ctrl_if.sv
      - rtl/lvds_rx_regs.sv
      - rtl/lvds_rx_lane.sv
      - rtl/lvds_rx_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/lvds_rx_checker.sv
      - bench/tb_lvds_rx.sv
